//--- include/pcie_core_defs.svh
/* Stream sizes, bank geometry, TLP header field positions and fmt/type codes */
`ifndef PCIE_CORE_DEFS_SVH
`define PCIE_CORE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream and bank sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SEG_COUNT       2       // Segments per beat and bank engines, power of two
`define SEG_DATA_WIDTH  32      // One dword per segment
`define SEG_HDR_WIDTH   128
`define BANK_ADDR_WIDTH 4       // 16 registers per bank

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header fields, DW0 in the top bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HDR_FMT_TYPE    127:120
`define HDR_LEN         105:96  // Length in dwords
`define HDR_RID         95:80   // Requester id
`define HDR_TAG         79:72
`define HDR_ADDR_LSB    34      // Dword address of a 32-bit request starts here

// Completion fields
`define CPL_CID         95:80   // Completer id
`define CPL_BC          75:64   // Byte count
`define CPL_RID         63:48
`define CPL_TAG         47:40
`define CPL_LADDR       38:32   // Lower address

`define FT_MRD32        8'h00
`define FT_MWR32        8'h40
`define FT_CPLD         8'h4a

`endif

//--- hw/pcie_core_pkg.sv
/* Decoded TLP operation and RX steering state */
package pcie_core_pkg;

    // Operation handed from steering to a bank engine
    typedef enum logic [1:0] {
        OP_MEM_WR = 2'd0,   // 32-bit memory write, one dword
        OP_MEM_RD = 2'd1,   // 32-bit memory read, one dword
        OP_DROP   = 2'd2    // Anything else, counted and discarded
    } tlp_op_t;

    typedef enum logic {
        ST_IDLE = 1'b0,     // Taking new beats
        ST_HOLD = 1'b1      // Conflicting segment waits for its bank
    } steer_state_t;

endpackage

//--- hw/rx_bank_steer.sv
/* RX segment decode, steering by address bit with same-bank hold, drop counter */
`timescale 1ns/1ps
`include "pcie_core_defs.svh"

module rx_bank_steer (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        user_pb,    // Clears drop count
    output logic [3:0]                                  user_led_g,

    input  logic [`SEG_COUNT*`SEG_DATA_WIDTH-1:0]       rx_st_data,
    input  logic [`SEG_COUNT*`SEG_HDR_WIDTH-1:0]        rx_st_hdr,
    input  logic [`SEG_COUNT-1:0]                       rx_st_sop,
    input  logic [`SEG_COUNT-1:0]                       rx_st_eop,
    input  logic [`SEG_COUNT-1:0]                       rx_st_valid,
    input  logic [`SEG_COUNT-1:0]                       rx_st_tlp_abort,
    output logic                                        rx_st_ready,

    input  logic [`SEG_COUNT-1:0]                       busy,       // One per bank
    output logic [`SEG_COUNT-1:0]                       req_valid,
    output pcie_core_pkg::tlp_op_t [`SEG_COUNT-1:0]     req_op,
    output logic [`SEG_COUNT-1:0][`BANK_ADDR_WIDTH-1:0] req_addr,
    output logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0]  req_data,
    output logic [`SEG_COUNT-1:0][7:0]                  req_tag,
    output logic [`SEG_COUNT-1:0][15:0]                 req_rid
);
    import pcie_core_pkg::*;

    localparam int SEL_W = $clog2(`SEG_COUNT);              // Interleave bits

    steer_state_t state;
    logic [`SEG_COUNT-1:0] hold_vld;                        // Segments still to issue
    logic [`SEG_COUNT-1:0][`SEG_HDR_WIDTH-1:0] hold_hdr;
    logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0] hold_data;
    logic [3:0] drop_cnt;

    logic [`SEG_COUNT-1:0][`SEG_HDR_WIDTH-1:0] src_hdr;     // Beat being steered
    logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0] src_data;
    logic [`SEG_COUNT-1:0] src_ok;                          // Single beat, not aborted
    logic [`SEG_COUNT-1:0] pend;
    tlp_op_t [`SEG_COUNT-1:0] op;
    logic [`SEG_COUNT-1:0] drop;
    logic [`SEG_COUNT-1:0] hold_nxt;
    logic [`SEG_COUNT-1:0] issue;                           // Per bank
    logic [`SEG_COUNT-1:0][SEL_W-1:0] issue_seg;            // Source segment per bank
    logic [3:0] n_drop;

    // Only one-dword MWr32 and MRd32 survive
    function automatic tlp_op_t decode(input logic [`SEG_HDR_WIDTH-1:0] hdr, input logic ok);
        tlp_op_t o;
        o = OP_DROP;
        if (ok && hdr[`HDR_LEN] == 10'd1) begin
            case (hdr[`HDR_FMT_TYPE])
                `FT_MWR32: o = OP_MEM_WR;
                `FT_MRD32: o = OP_MEM_RD;
                default:   o = OP_DROP;
            endcase
        end
        return o;
    endfunction

    assign rx_st_ready = (state == ST_IDLE) && !(|busy);    // Stall on hold or read in flight
    assign user_led_g  = drop_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source select and steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (state == ST_HOLD) begin
            src_hdr  = hold_hdr;                            // Replay of the held beat
            src_data = hold_data;
            src_ok   = '1;                                  // Already checked on entry
            pend     = hold_vld;
        end else begin
            src_hdr  = rx_st_hdr;
            src_data = rx_st_data;
            src_ok   = rx_st_sop & rx_st_eop & ~rx_st_tlp_abort;
            pend     = rx_st_valid & {`SEG_COUNT{rx_st_ready}};
        end
    end

    always_comb begin
        logic [SEL_W-1:0] bank;
        issue     = '0;
        issue_seg = '0;
        hold_nxt  = '0;
        drop      = '0;
        n_drop    = '0;
        for (int i = 0; i < `SEG_COUNT; i++) begin
            op[i] = decode(src_hdr[i], src_ok[i]);
            bank  = src_hdr[i][`HDR_ADDR_LSB +: SEL_W];     // Lowest dword address bit
            if (pend[i] && op[i] == OP_DROP) begin
                drop[i] = 1'b1;
                n_drop  = n_drop + 4'd1;
            end else if (pend[i]) begin
                // Lower segment wins the bank, a busy bank keeps it waiting
                if (!issue[bank] && !busy[bank]) begin
                    issue[bank]     = 1'b1;
                    issue_seg[bank] = SEL_W'(i);
                end else begin
                    hold_nxt[i] = 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            hold_vld  <= '0;
            req_valid <= '0;
            drop_cnt  <= '0;
        end else begin
            state     <= (|hold_nxt) ? ST_HOLD : ST_IDLE;
            hold_vld  <= hold_nxt;
            req_valid <= issue;                             // One-cycle strobe per bank
            drop_cnt  <= user_pb ? 4'd0 : drop_cnt + n_drop; // Wraps modulo 16
        end
    end

    always_ff @(posedge clk) begin
        if (rx_st_ready) begin
            hold_hdr  <= rx_st_hdr;
            hold_data <= rx_st_data;
        end
        for (int b = 0; b < `SEG_COUNT; b++) begin
            if (issue[b]) begin
                req_op[b]   <= op[issue_seg[b]];
                req_addr[b] <= src_hdr[issue_seg[b]][`HDR_ADDR_LSB+SEL_W +: `BANK_ADDR_WIDTH];
                req_data[b] <= src_data[issue_seg[b]];
                req_tag[b]  <= src_hdr[issue_seg[b]][`HDR_TAG];
                req_rid[b]  <= src_hdr[issue_seg[b]][`HDR_RID];
            end
        end
    end

    // Every issued segment gets a bank of its own
    assert property (@(posedge clk) disable iff (!rst_n)
        $countones(pend & ~drop & ~hold_nxt) == $countones(issue));

endmodule

//--- hw/tlp_bank_engine.sv
/* One register bank: executes writes, turns reads into CplD completions */
`timescale 1ns/1ps
`include "pcie_core_defs.svh"

module tlp_bank_engine #(
    parameter int BANK_IDX = 0                      // Interleave bits served here
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  pcie_core_pkg::tlp_op_t      req_op,
    input  logic [`BANK_ADDR_WIDTH-1:0] req_addr,
    input  logic [`SEG_DATA_WIDTH-1:0]  req_data,
    input  logic [7:0]                  req_tag,
    input  logic [15:0]                 req_rid,
    output logic                        busy,
    output logic                        cpl_valid,  // Level until taken
    output logic [`SEG_HDR_WIDTH-1:0]   cpl_hdr,
    output logic [`SEG_DATA_WIDTH-1:0]  cpl_data,
    input  logic                        cpl_take
);
    import pcie_core_pkg::*;

    localparam int SEL_W = $clog2(`SEG_COUNT);

    logic [`SEG_DATA_WIDTH-1:0] regs [2**`BANK_ADDR_WIDTH];

    // Request stage, one cycle behind req_valid
    logic                        stg_valid;
    tlp_op_t                     stg_op;
    logic [`BANK_ADDR_WIDTH-1:0] stg_addr;
    logic [`SEG_DATA_WIDTH-1:0]  stg_data;
    logic [7:0]                  stg_tag;
    logic [15:0]                 stg_rid;

    logic                              stg_rd;
    logic [`BANK_ADDR_WIDTH+SEL_W+1:0] byte_addr;   // Full byte address of the read

    assign stg_rd    = stg_valid && (stg_op == OP_MEM_RD);
    assign byte_addr = {stg_addr, SEL_W'(BANK_IDX), 2'b00};

    // Busy from the read strobe until the completion leaves
    assign busy = cpl_valid || stg_rd || (req_valid && req_op == OP_MEM_RD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_valid <= 1'b0;
        end else begin
            stg_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            stg_op   <= req_op;
            stg_addr <= req_addr;
            stg_data <= req_data;
            stg_tag  <= req_tag;
            stg_rid  <= req_rid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpl_valid <= 1'b0;
            for (int i = 0; i < 2**`BANK_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (stg_valid && stg_op == OP_MEM_WR) begin
                regs[stg_addr] <= stg_data;
            end
            if (stg_rd) begin
                cpl_valid <= 1'b1;
            end else if (cpl_take) begin
                cpl_valid <= 1'b0;
            end
        end
    end

    // CplD header, all other fields zero
    always_ff @(posedge clk) begin
        if (stg_rd) begin
            cpl_hdr                <= '0;
            cpl_hdr[`HDR_FMT_TYPE] <= `FT_CPLD;
            cpl_hdr[`HDR_LEN]      <= 10'd1;
            cpl_hdr[`CPL_CID]      <= 16'h0000;         // No config space here
            cpl_hdr[`CPL_BC]       <= 12'd4;
            cpl_hdr[`CPL_RID]      <= stg_rid;
            cpl_hdr[`CPL_TAG]      <= stg_tag;
            cpl_hdr[`CPL_LADDR]    <= byte_addr[6:0];
            cpl_data               <= regs[stg_addr];
        end
    end

    // Steering holds off while a read of this bank is outstanding
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !(cpl_valid || stg_rd));

endmodule

//--- hw/cpl_tx_merge.sv
/* Completion merger: packs bank completions into one registered TX beat */
`timescale 1ns/1ps
`include "pcie_core_defs.svh"

module cpl_tx_merge (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`SEG_COUNT-1:0]                       cpl_valid,
    input  logic [`SEG_COUNT-1:0][`SEG_HDR_WIDTH-1:0]   cpl_hdr,
    input  logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0]  cpl_data,
    output logic [`SEG_COUNT-1:0]                       cpl_take,

    output logic [`SEG_COUNT*`SEG_DATA_WIDTH-1:0]       tx_st_data,
    output logic [`SEG_COUNT*`SEG_HDR_WIDTH-1:0]        tx_st_hdr,
    output logic [`SEG_COUNT-1:0]                       tx_st_sop,
    output logic [`SEG_COUNT-1:0]                       tx_st_eop,
    output logic [`SEG_COUNT-1:0]                       tx_st_valid,
    output logic [`SEG_COUNT-1:0]                       tx_st_err,
    input  logic                                        tx_st_ready
);
    logic                                       load;   // Output stage free or drained
    logic [`SEG_COUNT-1:0]                      nxt_valid;
    logic [`SEG_COUNT-1:0][`SEG_HDR_WIDTH-1:0]  nxt_hdr;
    logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0] nxt_data;

    assign load      = !(|tx_st_valid) || tx_st_ready;
    assign cpl_take  = cpl_valid & {`SEG_COUNT{load}};
    assign tx_st_sop = tx_st_valid;                     // Single-beat TLPs only
    assign tx_st_eop = tx_st_valid;
    assign tx_st_err = '0;

    // Pack into the lowest segments, bank order
    always_comb begin
        int k;
        k         = 0;
        nxt_valid = '0;
        nxt_hdr   = '0;
        nxt_data  = '0;
        for (int b = 0; b < `SEG_COUNT; b++) begin
            if (cpl_valid[b]) begin
                nxt_valid[k] = 1'b1;
                nxt_hdr[k]   = cpl_hdr[b];
                nxt_data[k]  = cpl_data[b];
                k            = k + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_st_valid <= '0;
        end else if (load) begin
            tx_st_valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_st_hdr  <= nxt_hdr;
            tx_st_data <= nxt_data;
        end
    end

    // Stalled beat holds steady
    assert property (@(posedge clk) disable iff (!rst_n)
        (|tx_st_valid && !tx_st_ready) |=>
            $stable(tx_st_valid) && $stable(tx_st_hdr) && $stable(tx_st_data));

endmodule

//--- hw/fpga_core.sv
/* Top level: RX steering, interleaved bank engines, completion merger */
`timescale 1ns/1ps
`include "pcie_core_defs.svh"

module fpga_core (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // GPIO
    input  logic                                    user_pb,
    output logic [3:0]                              user_led_g,     // Drop count

    // RX stream
    input  logic [`SEG_COUNT*`SEG_DATA_WIDTH-1:0]   rx_st_data,
    input  logic [`SEG_COUNT*`SEG_HDR_WIDTH-1:0]    rx_st_hdr,
    input  logic [`SEG_COUNT-1:0]                   rx_st_sop,
    input  logic [`SEG_COUNT-1:0]                   rx_st_eop,
    input  logic [`SEG_COUNT-1:0]                   rx_st_valid,
    input  logic [`SEG_COUNT-1:0]                   rx_st_tlp_abort,
    output logic                                    rx_st_ready,

    // TX stream
    output logic [`SEG_COUNT*`SEG_DATA_WIDTH-1:0]   tx_st_data,
    output logic [`SEG_COUNT*`SEG_HDR_WIDTH-1:0]    tx_st_hdr,
    output logic [`SEG_COUNT-1:0]                   tx_st_sop,
    output logic [`SEG_COUNT-1:0]                   tx_st_eop,
    output logic [`SEG_COUNT-1:0]                   tx_st_valid,
    output logic [`SEG_COUNT-1:0]                   tx_st_err,
    input  logic                                    tx_st_ready
);
    import pcie_core_pkg::*;

    // Steering to banks
    logic [`SEG_COUNT-1:0]                      req_valid;
    tlp_op_t [`SEG_COUNT-1:0]                   req_op;
    logic [`SEG_COUNT-1:0][`BANK_ADDR_WIDTH-1:0] req_addr;
    logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0] req_data;
    logic [`SEG_COUNT-1:0][7:0]                 req_tag;
    logic [`SEG_COUNT-1:0][15:0]                req_rid;
    logic [`SEG_COUNT-1:0]                      busy;

    // Banks to merger
    logic [`SEG_COUNT-1:0]                      cpl_valid;
    logic [`SEG_COUNT-1:0][`SEG_HDR_WIDTH-1:0]  cpl_hdr;
    logic [`SEG_COUNT-1:0][`SEG_DATA_WIDTH-1:0] cpl_data;
    logic [`SEG_COUNT-1:0]                      cpl_take;

    rx_bank_steer i_rx_bank_steer (
        .clk             (clk),
        .rst_n           (rst_n),
        .user_pb         (user_pb),
        .user_led_g      (user_led_g),
        .rx_st_data      (rx_st_data),
        .rx_st_hdr       (rx_st_hdr),
        .rx_st_sop       (rx_st_sop),
        .rx_st_eop       (rx_st_eop),
        .rx_st_valid     (rx_st_valid),
        .rx_st_tlp_abort (rx_st_tlp_abort),
        .rx_st_ready     (rx_st_ready),
        .busy            (busy),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_data        (req_data),
        .req_tag         (req_tag),
        .req_rid         (req_rid)
    );

    // One engine per interleave slot
    for (genvar i = 0; i < `SEG_COUNT; i++) begin : g_bank
        tlp_bank_engine #(.BANK_IDX(i)) i_tlp_bank_engine (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_valid (req_valid[i]),
            .req_op    (req_op[i]),
            .req_addr  (req_addr[i]),
            .req_data  (req_data[i]),
            .req_tag   (req_tag[i]),
            .req_rid   (req_rid[i]),
            .busy      (busy[i]),
            .cpl_valid (cpl_valid[i]),
            .cpl_hdr   (cpl_hdr[i]),
            .cpl_data  (cpl_data[i]),
            .cpl_take  (cpl_take[i])
        );
    end

    cpl_tx_merge i_cpl_tx_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpl_valid   (cpl_valid),
        .cpl_hdr     (cpl_hdr),
        .cpl_data    (cpl_data),
        .cpl_take    (cpl_take),
        .tx_st_data  (tx_st_data),
        .tx_st_hdr   (tx_st_hdr),
        .tx_st_sop   (tx_st_sop),
        .tx_st_eop   (tx_st_eop),
        .tx_st_valid (tx_st_valid),
        .tx_st_err   (tx_st_err),
        .tx_st_ready (tx_st_ready)
    );

endmodule

//--- verification/tb_fpga_core.sv
/* Testbench: clock, reset, segmented RX stimulus, register reference model,
   TX completion checker and cycle timeout */
`timescale 1ns/1ps
`include "pcie_core_defs.svh"

module tb_fpga_core;

    localparam int SEGS   = `SEG_COUNT;
    localparam int HW     = `SEG_HDR_WIDTH;
    localparam int DW     = `SEG_DATA_WIDTH;
    localparam int AW     = `BANK_ADDR_WIDTH + $clog2(`SEG_COUNT);  // Dword address over all banks
    localparam int K_WR   = 0;
    localparam int K_RD   = 1;
    localparam int K_DROP = 2;
    localparam int MAX_CYCLES = 4000;   // About 210 beats at up to 12 cycles each plus drains

    typedef struct packed {
        logic [7:0]    tag;
        logic [15:0]   rid;
        logic [DW-1:0] data;
        logic [AW-1:0] addr;
    } cpl_exp_t;

    logic               clk;
    logic               rst_n;
    logic               user_pb;
    logic [3:0]         user_led_g;
    logic [SEGS*DW-1:0] rx_st_data;
    logic [SEGS*HW-1:0] rx_st_hdr;
    logic [SEGS-1:0]    rx_st_sop;
    logic [SEGS-1:0]    rx_st_eop;
    logic [SEGS-1:0]    rx_st_valid;
    logic [SEGS-1:0]    rx_st_tlp_abort;
    logic               rx_st_ready;
    logic [SEGS*DW-1:0] tx_st_data;
    logic [SEGS*HW-1:0] tx_st_hdr;
    logic [SEGS-1:0]    tx_st_sop;
    logic [SEGS-1:0]    tx_st_eop;
    logic [SEGS-1:0]    tx_st_valid;
    logic [SEGS-1:0]    tx_st_err;
    logic               tx_st_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [DW-1:0] ref_mem [2**AW];     // Whole register space with the bank in address bit 0
    cpl_exp_t      exp_q [$];           // Outstanding reads searched by tag
    int            drop_total;
    logic [6:0]    next_tag;            // Next read tag
    int            cycles;
    logic          rand_ready;          // Random TX back-pressure when set

    // Beat being built
    logic [HW-1:0] seg_hdr [SEGS];
    logic [DW-1:0] seg_data [SEGS];
    logic [AW-1:0] seg_addr [SEGS];
    int            seg_kind [SEGS];
    logic [SEGS-1:0] seg_vld;
    logic [SEGS-1:0] seg_framed;        // sop and eop both set
    logic [SEGS-1:0] seg_abort;

    // Stall tracking for the checker
    logic               stalled;
    logic [SEGS-1:0]    held_valid;
    logic [SEGS*HW-1:0] held_hdr;
    logic [SEGS*DW-1:0] held_data;

    fpga_core i_fpga_core (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    function automatic logic [DW-1:0] ref_read(input logic [AW-1:0] addr);
        return ref_mem[addr];
    endfunction

    function automatic logic [HW-1:0] build_hdr(input logic [7:0] ft, input logic [9:0] len,
            input logic [15:0] rid, input logic [7:0] tag, input logic [AW-1:0] addr);
        logic [HW-1:0] h;
        h                      = '0;
        h[`HDR_FMT_TYPE]       = ft;
        h[`HDR_LEN]            = len;
        h[`HDR_RID]            = rid;
        h[`HDR_TAG]            = tag;
        h[`HDR_ADDR_LSB +: AW] = addr;  // Dword address in the low bits
        return h;
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic fail_value(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Classify as the core should and stage the segment
    task automatic load_seg(input int s, input logic [7:0] ft, input logic [9:0] len,
            input logic [AW-1:0] addr, input logic [DW-1:0] data,
            input logic framed, input logic abort);
        logic [7:0] tag;
        int kind;
        kind = K_DROP;
        if (framed && !abort && len == 10'd1 && ft == `FT_MWR32) kind = K_WR;
        if (framed && !abort && len == 10'd1 && ft == `FT_MRD32) kind = K_RD;
        tag = 8'hff;                    // Tag of a TLP that gets dropped
        if (kind == K_RD) begin
            tag      = {1'b0, next_tag};
            next_tag = next_tag + 7'd1;
        end
        seg_hdr[s]    = build_hdr(ft, len, 16'($urandom), tag, addr);
        seg_data[s]   = data;
        seg_addr[s]   = addr;
        seg_kind[s]   = kind;
        seg_vld[s]    = 1'b1;
        seg_framed[s] = framed;
        seg_abort[s]  = abort;
    endtask

    task automatic write_seg(input int s, input logic [AW-1:0] addr, input logic [DW-1:0] data);
        load_seg(s, `FT_MWR32, 10'd1, addr, data, 1'b1, 1'b0);
    endtask

    task automatic read_seg(input int s, input logic [AW-1:0] addr);
        load_seg(s, `FT_MRD32, 10'd1, addr, $urandom, 1'b1, 1'b0);
    endtask

    task automatic rand_seg(input int s, input logic [AW-1:0] addr);
        if ($urandom % 2) write_seg(s, addr, $urandom);
        else read_seg(s, addr);
    endtask

    // Drive the staged beat, hold it until taken, then update the model
    task automatic send_beat();
        cpl_exp_t e;
        for (int s = 0; s < SEGS; s++) begin
            rx_st_hdr[s*HW +: HW]  = seg_hdr[s];
            rx_st_data[s*DW +: DW] = seg_data[s];
        end
        rx_st_valid     = seg_vld;
        rx_st_sop       = seg_framed;
        rx_st_eop       = seg_framed;
        rx_st_tlp_abort = seg_abort;
        while (!rx_st_ready) begin      // Ready is settled 1 ns after the edge
            @(posedge clk);
            #1;
        end
        @(posedge clk);                 // Taken here
        #1;
        for (int s = 0; s < SEGS; s++) begin
            if (seg_vld[s]) begin       // In segment order so seg 1 sees seg 0 writes
                case (seg_kind[s])
                    K_WR: ref_mem[seg_addr[s]] = seg_data[s];
                    K_RD: begin
                        e.tag  = seg_hdr[s][`HDR_TAG];
                        e.rid  = seg_hdr[s][`HDR_RID];
                        e.data = ref_read(seg_addr[s]);
                        e.addr = seg_addr[s];
                        exp_q.push_back(e);
                    end
                    default: drop_total++;
                endcase
            end
        end
        rx_st_valid = '0;
        seg_vld     = '0;
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (exp_q.size() != 0 && guard < 200) begin
            @(posedge clk);
            #1;
            guard++;
        end
        repeat (4) begin                // Room for a late duplicate to show up
            @(posedge clk);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // TX checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_beat();
        logic [HW-1:0] h;
        logic [DW-1:0] d;
        int idx;
        assert ((tx_st_valid & (tx_st_valid + 1'b1)) == '0)
            else fail_value($sformatf("TX valid %b not packed low", tx_st_valid));
        for (int s = 0; s < SEGS; s++) begin
            if (tx_st_valid[s]) begin
                h   = tx_st_hdr[s*HW +: HW];
                d   = tx_st_data[s*DW +: DW];
                idx = -1;
                for (int i = 0; i < exp_q.size(); i++) begin
                    if (exp_q[i].tag == h[`CPL_TAG]) idx = i;
                end
                assert (idx >= 0)
                    else fail_value($sformatf("completion tag %0h not expected", h[`CPL_TAG]));
                assert (tx_st_sop[s] && tx_st_eop[s])
                    else fail_value($sformatf("seg %0d missing sop or eop", s));
                assert (h[`HDR_FMT_TYPE] == `FT_CPLD && h[`HDR_LEN] == 10'd1)
                    else fail_value($sformatf("seg %0d not a one-dword CplD", s));
                assert (h[`CPL_RID] == exp_q[idx].rid && h[`CPL_CID] == 16'h0)
                    else fail_value($sformatf("tag %0h wrong requester or completer id",
                        h[`CPL_TAG]));
                assert (d == exp_q[idx].data)
                    else fail_value($sformatf("tag %0h data %h, expected %h",
                        h[`CPL_TAG], d, exp_q[idx].data));
                assert (h[`CPL_BC] == 12'd4)
                    else fail_value($sformatf("tag %0h byte count %0d", h[`CPL_TAG], h[`CPL_BC]));
                assert (h[`CPL_LADDR] == {exp_q[idx].addr, 2'b00})
                    else fail_value($sformatf("tag %0h lower address %h", h[`CPL_TAG],
                        h[`CPL_LADDR]));
                exp_q.delete(idx);
            end
        end
    endtask

    // Sampled mid-cycle where outputs and ready are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                assert (tx_st_valid == held_valid && tx_st_hdr == held_hdr &&
                        tx_st_data == held_data)
                    else fail_value("TX beat changed while stalled");
            end
            assert (tx_st_err == '0) else fail_value("tx_st_err set");
            if (|tx_st_valid && tx_st_ready) check_beat();
            stalled    = |tx_st_valid && !tx_st_ready;
            held_valid = tx_st_valid;
            held_hdr   = tx_st_hdr;
            held_data  = tx_st_data;
        end
    end

    always @(posedge clk) begin
        #1;
        tx_st_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [AW-1:0] a;
        logic [AW-1:0] b;
        void'($urandom(21354));
        cycles          = 0;
        drop_total      = 0;
        next_tag        = '0;
        rand_ready      = 1'b0;
        stalled         = 1'b0;
        seg_vld         = '0;
        rst_n           = 1'b0;
        user_pb         = 1'b0;
        rx_st_data      = '0;
        rx_st_hdr       = '0;
        rx_st_sop       = '0;
        rx_st_eop       = '0;
        rx_st_valid     = '0;
        rx_st_tlp_abort = '0;
        tx_st_ready     = 1'b1;
        for (int i = 0; i < 2**AW; i++) begin
            ref_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (rx_st_ready && tx_st_valid == '0 && user_led_g == 4'd0)
            else fail_value("outputs not at reset values");

        // Writes to the low half and reads of everything
        for (int i = 0; i < 2**(AW-1); i++) begin
            write_seg(i % SEGS, AW'(i), $urandom);
            send_beat();
        end
        for (int i = 0; i < 2**AW; i++) begin
            read_seg(i % SEGS, AW'(i));
            send_beat();
        end
        wait_idle();

        // Two segments for different banks
        for (int i = 0; i < 60; i++) begin
            a    = AW'($urandom);
            b    = AW'($urandom);
            b[0] = ~a[0];
            rand_seg(0, a);
            rand_seg(1, b);
            send_beat();
        end
        wait_idle();

        // Same bank and address with write then read and read then write
        for (int i = 0; i < 30; i++) begin
            a = AW'($urandom);
            if (i < 20) begin
                write_seg(0, a, $urandom);
                read_seg(1, a);
            end else begin
                read_seg(0, a);
                write_seg(1, a, $urandom);
            end
            send_beat();
        end
        wait_idle();

        // Random back-pressure on TX with any bank mix
        rand_ready = 1'b1;
        for (int i = 0; i < 60; i++) begin
            rand_seg(0, AW'($urandom));
            rand_seg(1, AW'($urandom));
            send_beat();
        end
        wait_idle();
        rand_ready = 1'b0;

        // Dropped TLPs next to live reads
        for (int i = 0; i < 20; i++) begin
            a = AW'($urandom);
            case (i % 4)
                0: load_seg(0, 8'h04, 10'd1, a, $urandom, 1'b1, 1'b0);     // CfgRd0
                1: load_seg(0, `FT_MWR32, 10'd1, a, $urandom, 1'b1, 1'b1); // Aborted
                2: load_seg(0, `FT_MRD32, 10'd2, a, $urandom, 1'b1, 1'b0); // Two dwords
                default: load_seg(0, `FT_MWR32, 10'd1, a, $urandom, 1'b0, 1'b0);
            endcase
            if (i % 2) load_seg(1, 8'h20, 10'd1, a, '0, 1'b1, 1'b0);       // MRd64
            else read_seg(1, a);
            send_beat();
        end
        wait_idle();
        assert (user_led_g == 4'(drop_total % 16))
            else fail_value($sformatf("LED %0d, expected %0d", user_led_g, drop_total % 16));
        user_pb = 1'b1;
        @(posedge clk);
        #1;
        user_pb    = 1'b0;
        drop_total = 0;
        assert (user_led_g == 4'd0) else fail_value("LED not cleared by user_pb");

        wait_idle();
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d expected completions never arrived on TX", exp_q.size());
            abort_run();
        end
    end

endmodule

//--- build.f
+incdir+include
hw/pcie_core_pkg.sv
hw/rx_bank_steer.sv
hw/tlp_bank_engine.sv
hw/cpl_tx_merge.sv
hw/fpga_core.sv
verification/tb_fpga_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fpga_core testbench with Verilator and runs it.
# The exit status of the simulation binary is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_fpga_core \
    -j 0

./obj_dir/Vtb_fpga_core
